// ==== soc_periph_pkg.sv ====
// Peripheral subsystem package with bus widths, address map and register offsets
`default_nettype none

package soc_periph_pkg;

  // Bus geometry
  localparam int bus_addr_width = 32;
  localparam int bus_data_width = 32;
  localparam int bus_be_width   = 4;

  // Device base addresses, each device owns one 4 KiB window
  localparam logic [bus_addr_width-1:0] gpio_start  = 32'h8000_0000;
  localparam logic [bus_addr_width-1:0] timer_start = 32'h8000_2000;
  localparam logic [bus_addr_width-1:0] pwm_start   = 32'h8000_3000;
  localparam logic [bus_addr_width-1:0] dev_mask    = 32'hFFFF_F000;

  typedef enum logic [1:0] {
    dev_gpio,
    dev_timer,
    dev_pwm
  } dev_e;

  localparam int nr_devices = 3;

  // Base table in dev_e order
  localparam logic [bus_addr_width-1:0] dev_base [nr_devices] = '{
    gpio_start,
    timer_start,
    pwm_start
  };

  // GPIO registers
  localparam logic [bus_addr_width-1:0] gpio_out_off = 32'h0;
  localparam logic [bus_addr_width-1:0] gpio_in_off  = 32'h4;

  // Timer registers
  localparam logic [bus_addr_width-1:0] timer_mtime_lo_off = 32'h0;
  localparam logic [bus_addr_width-1:0] timer_mtime_hi_off = 32'h4;
  localparam logic [bus_addr_width-1:0] timer_cmp_lo_off   = 32'h8;
  localparam logic [bus_addr_width-1:0] timer_cmp_hi_off   = 32'hC;

  // PWM registers, repeated once per channel window
  localparam logic [bus_addr_width-1:0] pwm_period_off  = 32'h0;
  localparam logic [bus_addr_width-1:0] pwm_width_off   = 32'h4;
  localparam logic [bus_addr_width-1:0] pwm_chan_stride = 32'h8;

endpackage

`default_nettype wire

// ==== dev_bus_if.sv ====
// Device bus interface carrying one device's request strobe and its response
`default_nettype none

interface dev_bus_if;
  import soc_periph_pkg::*;

  // Request side, driven by the decoder
  logic                      req;
  logic [bus_addr_width-1:0] addr;
  logic                      we;
  logic [bus_be_width-1:0]   be;
  logic [bus_data_width-1:0] wdata;

  // Response side, one cycle after req
  logic                      rvalid;
  logic [bus_data_width-1:0] rdata;
  logic                      err;

  modport host (
    output req, addr, we, be, wdata,
    input  rvalid, rdata, err
  );

  modport device (
    input  req, addr, we, be, wdata,
    output rvalid, rdata, err
  );

endinterface

`default_nettype wire

// ==== pwm_channel.sv ====
// PWM channel with a wrapping counter compared against the pulse width
`default_nettype none

module pwm_channel #(
  parameter int pwm_ctr_size = 8
) (
  input  wire logic                    clk_sys_i,
  input  wire logic                    rst_sys_ni,

  input  wire logic [pwm_ctr_size-1:0] period_i,
  input  wire logic [pwm_ctr_size-1:0] width_i,
  output      logic                    pwm_o
);

  logic [pwm_ctr_size-1:0] ctr_q;

  // Full cycle is period plus one clocks
  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      ctr_q <= '0;
    end else if (ctr_q >= period_i) begin
      // Also recovers when period drops below the running count
      ctr_q <= '0;
    end else begin
      ctr_q <= ctr_q + 1'b1;
    end
  end

  assign pwm_o = ctr_q < width_i;

endmodule

`default_nettype wire

// ==== pwm_regs.sv ====
// PWM register file with per-channel period and width feeding identical channels
`default_nettype none

module pwm_regs #(
  parameter int pwm_width    = 12,
  parameter int pwm_ctr_size = 8
) (
  input  wire logic                 clk_sys_i,
  input  wire logic                 rst_sys_ni,

  dev_bus_if.device                 bus_i,

  output      logic [pwm_width-1:0] pwm_o
);
  import soc_periph_pkg::*;

  logic [pwm_ctr_size-1:0]   period_q [pwm_width];
  logic [pwm_ctr_size-1:0]   width_q  [pwm_width];
  logic [bus_addr_width-1:0] chan_idx;
  logic [bus_addr_width-1:0] reg_off;
  logic                      wr;
  logic [bus_data_width-1:0] rd_data;
  logic [bus_data_width-1:0] rdata_q;
  logic                      rvalid_q;

  // Channel window and register within it
  assign chan_idx = bus_i.addr / pwm_chan_stride;
  assign reg_off  = bus_i.addr % pwm_chan_stride;
  assign wr       = bus_i.req & bus_i.we;

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      for (int c = 0; c < pwm_width; c++) begin
        period_q[c] <= '0;
        width_q[c]  <= '0;
      end
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus_i.req;
      for (int c = 0; c < pwm_width; c++) begin
        if (wr && chan_idx == c && reg_off == pwm_period_off) begin
          period_q[c] <= bus_i.wdata[pwm_ctr_size-1:0];
        end
        if (wr && chan_idx == c && reg_off == pwm_width_off) begin
          width_q[c] <= bus_i.wdata[pwm_ctr_size-1:0];
        end
      end
    end
  end

  // Channels past pwm_width never match and read zero
  always_comb begin
    rd_data = '0;
    for (int c = 0; c < pwm_width; c++) begin
      if (chan_idx == c && reg_off == pwm_period_off) begin
        rd_data[pwm_ctr_size-1:0] = period_q[c];
      end else if (chan_idx == c && reg_off == pwm_width_off) begin
        rd_data[pwm_ctr_size-1:0] = width_q[c];
      end
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (bus_i.req) begin
      rdata_q <= bus_i.we ? '0 : rd_data;
    end
  end

  assign bus_i.rvalid = rvalid_q;
  assign bus_i.rdata  = rdata_q;
  assign bus_i.err    = 1'b0;

  for (genvar c = 0; c < pwm_width; c++) begin : g_chan
    pwm_channel #(
      .pwm_ctr_size (pwm_ctr_size)
    ) u_chan (
      .clk_sys_i  (clk_sys_i),
      .rst_sys_ni (rst_sys_ni),
      .period_i   (period_q[c]),
      .width_i    (width_q[c]),
      .pwm_o      (pwm_o[c])
    );
  end

endmodule

`default_nettype wire

// ==== gpio_regs.sv ====
// GPIO block with a byte-writable output register and a synchronized input register
`default_nettype none

module gpio_regs #(
  parameter int gpi_width = 8,
  parameter int gpo_width = 16
) (
  input  wire logic                 clk_sys_i,
  input  wire logic                 rst_sys_ni,

  dev_bus_if.device                 bus_i,

  input  wire logic [gpi_width-1:0] gp_i,
  output      logic [gpo_width-1:0] gp_o
);
  import soc_periph_pkg::*;

  logic [gpo_width-1:0]      gp_out_q;
  logic [gpi_width-1:0]      gp_meta_q;
  logic [gpi_width-1:0]      gp_sync_q;
  logic [bus_data_width-1:0] rd_data;
  logic [bus_data_width-1:0] rdata_q;
  logic                      rvalid_q;
  logic                      wr_out;

  assign wr_out = bus_i.req & bus_i.we & (bus_i.addr == gpio_out_off);

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      gp_out_q  <= '0;
      gp_meta_q <= '0;
      gp_sync_q <= '0;
      rvalid_q  <= 1'b0;
    end else begin
      // Two-flop synchronizer on the pins
      gp_meta_q <= gp_i;
      gp_sync_q <= gp_meta_q;
      rvalid_q  <= bus_i.req;
      if (wr_out) begin
        for (int i = 0; i < gpo_width; i++) begin
          if (bus_i.be[i/8]) begin
            gp_out_q[i] <= bus_i.wdata[i];
          end
        end
      end
    end
  end

  always_comb begin
    rd_data = '0;
    if (bus_i.addr == gpio_out_off) begin
      rd_data[gpo_width-1:0] = gp_out_q;
    end else if (bus_i.addr == gpio_in_off) begin
      rd_data[gpi_width-1:0] = gp_sync_q;
    end
  end

  // Writes answer with zero data
  always_ff @(posedge clk_sys_i) begin
    if (bus_i.req) begin
      rdata_q <= bus_i.we ? '0 : rd_data;
    end
  end

  assign bus_i.rvalid = rvalid_q;
  assign bus_i.rdata  = rdata_q;
  assign bus_i.err    = 1'b0;
  assign gp_o         = gp_out_q;

endmodule

`default_nettype wire

// ==== timer_regs.sv ====
// Machine timer with 64-bit mtime, compare register and level interrupt
`default_nettype none

module timer_regs (
  input  wire logic clk_sys_i,
  input  wire logic rst_sys_ni,

  dev_bus_if.device bus_i,

  output      logic timer_irq_o
);
  import soc_periph_pkg::*;

  logic [63:0]               mtime_q;
  logic [63:0]               cmp_q;
  logic                      irq_q;
  logic                      wr;
  logic                      bad_off;
  logic [bus_data_width-1:0] rd_data;
  logic [bus_data_width-1:0] rdata_q;
  logic                      rvalid_q;
  logic                      err_q;

  assign wr = bus_i.req & bus_i.we;

  // Offset decode for reads and the error flag
  always_comb begin
    rd_data = '0;
    bad_off = 1'b0;
    case (bus_i.addr)
      timer_mtime_lo_off: rd_data = mtime_q[31:0];
      timer_mtime_hi_off: rd_data = mtime_q[63:32];
      timer_cmp_lo_off:   rd_data = cmp_q[31:0];
      timer_cmp_hi_off:   rd_data = cmp_q[63:32];
      default:            bad_off = 1'b1;
    endcase
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      mtime_q <= '0;
      cmp_q   <= '1;
      irq_q   <= 1'b0;
    end else begin
      // A write to mtime replaces the increment for that cycle
      if (wr && bus_i.addr == timer_mtime_lo_off) begin
        mtime_q[31:0] <= bus_i.wdata;
      end else if (wr && bus_i.addr == timer_mtime_hi_off) begin
        mtime_q[63:32] <= bus_i.wdata;
      end else begin
        mtime_q <= mtime_q + 64'd1;
      end
      if (wr && bus_i.addr == timer_cmp_lo_off) begin
        cmp_q[31:0] <= bus_i.wdata;
      end
      if (wr && bus_i.addr == timer_cmp_hi_off) begin
        cmp_q[63:32] <= bus_i.wdata;
      end
      irq_q <= mtime_q >= cmp_q;
    end
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      rvalid_q <= bus_i.req;
      err_q    <= bus_i.req & bad_off;
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (bus_i.req) begin
      rdata_q <= bus_i.we ? '0 : rd_data;
    end
  end

  assign bus_i.rvalid = rvalid_q;
  assign bus_i.rdata  = rdata_q;
  assign bus_i.err    = err_q;
  assign timer_irq_o  = irq_q;

  a_err_with_rvalid : assert property (
    @(posedge clk_sys_i) disable iff (!rst_sys_ni) bus_i.err |-> bus_i.rvalid
  );

endmodule

`default_nettype wire

// ==== periph_bus.sv ====
// Peripheral address decoder routing host requests to devices and merging responses
`default_nettype none

module periph_bus (
  input  wire logic                                      clk_sys_i,
  input  wire logic                                      rst_sys_ni,

  input  wire logic                                      host_req_i,
  input  wire logic [soc_periph_pkg::bus_addr_width-1:0] host_addr_i,
  input  wire logic                                      host_we_i,
  input  wire logic [soc_periph_pkg::bus_be_width-1:0]   host_be_i,
  input  wire logic [soc_periph_pkg::bus_data_width-1:0] host_wdata_i,
  output      logic                                      host_rvalid_o,
  output      logic [soc_periph_pkg::bus_data_width-1:0] host_rdata_o,
  output      logic                                      host_err_o,

  dev_bus_if.host                                        dev_o [soc_periph_pkg::nr_devices]
);
  import soc_periph_pkg::*;

  logic [nr_devices-1:0]     dev_hit;
  logic [nr_devices-1:0]     dev_req;
  logic [nr_devices-1:0]     dev_rvalid;
  logic [nr_devices-1:0]     dev_err;
  logic [bus_data_width-1:0] dev_rdata [nr_devices];
  logic                      miss;
  logic                      miss_q;

  for (genvar i = 0; i < nr_devices; i++) begin : g_dev
    assign dev_hit[i] = (host_addr_i & dev_mask) == dev_base[i];
    assign dev_req[i] = host_req_i & dev_hit[i];

    // Offset only, devices never see the base
    assign dev_o[i].req   = dev_req[i];
    assign dev_o[i].addr  = host_addr_i & ~dev_mask;
    assign dev_o[i].we    = host_we_i;
    assign dev_o[i].be    = host_be_i;
    assign dev_o[i].wdata = host_wdata_i;

    assign dev_rvalid[i] = dev_o[i].rvalid;
    assign dev_rdata[i]  = dev_o[i].rdata;
    assign dev_err[i]    = dev_o[i].err;
  end

  assign miss = host_req_i & ~|dev_hit;

  // Unmapped access answers on its own after one cycle
  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      miss_q <= 1'b0;
    end else begin
      miss_q <= miss;
    end
  end

  always_comb begin
    host_rvalid_o = miss_q;
    host_err_o    = miss_q;
    host_rdata_o  = '0;
    for (int i = 0; i < nr_devices; i++) begin
      if (dev_rvalid[i]) begin
        host_rvalid_o = 1'b1;
        host_rdata_o  = dev_rdata[i];
        host_err_o    = host_err_o | dev_err[i];
      end
    end
  end

  a_one_dev_req : assert property (
    @(posedge clk_sys_i) disable iff (!rst_sys_ni) $onehot0(dev_req)
  );

  // Every device and the miss path keep the one-cycle answer
  a_req_answered : assert property (
    @(posedge clk_sys_i) disable iff (!rst_sys_ni) host_req_i |=> host_rvalid_o
  );

endmodule

`default_nettype wire

// ==== periph_subsystem.sv ====
// Peripheral subsystem top with host port, address decoder, GPIO, timer and PWM
`default_nettype none

module periph_subsystem #(
  parameter int gpi_width    = 8,
  parameter int gpo_width    = 16,
  parameter int pwm_width    = 12,
  parameter int pwm_ctr_size = 8
) (
  input  wire logic                                      clk_sys_i,
  input  wire logic                                      rst_sys_ni,

  input  wire logic                                      host_req_i,
  input  wire logic [soc_periph_pkg::bus_addr_width-1:0] host_addr_i,
  input  wire logic                                      host_we_i,
  input  wire logic [soc_periph_pkg::bus_be_width-1:0]   host_be_i,
  input  wire logic [soc_periph_pkg::bus_data_width-1:0] host_wdata_i,
  output      logic                                      host_rvalid_o,
  output      logic [soc_periph_pkg::bus_data_width-1:0] host_rdata_o,
  output      logic                                      host_err_o,

  input  wire logic [gpi_width-1:0]                      gp_i,
  output      logic [gpo_width-1:0]                      gp_o,
  output      logic [pwm_width-1:0]                      pwm_o,
  output      logic                                      timer_irq_o
);
  import soc_periph_pkg::*;

  // One device port per entry of dev_e
  dev_bus_if dev_bus [nr_devices] ();

  periph_bus u_bus (
    .clk_sys_i     (clk_sys_i),
    .rst_sys_ni    (rst_sys_ni),
    .host_req_i    (host_req_i),
    .host_addr_i   (host_addr_i),
    .host_we_i     (host_we_i),
    .host_be_i     (host_be_i),
    .host_wdata_i  (host_wdata_i),
    .host_rvalid_o (host_rvalid_o),
    .host_rdata_o  (host_rdata_o),
    .host_err_o    (host_err_o),
    .dev_o         (dev_bus)
  );

  gpio_regs #(
    .gpi_width (gpi_width),
    .gpo_width (gpo_width)
  ) u_gpio (
    .clk_sys_i  (clk_sys_i),
    .rst_sys_ni (rst_sys_ni),
    .bus_i      (dev_bus[dev_gpio]),
    .gp_i       (gp_i),
    .gp_o       (gp_o)
  );

  timer_regs u_timer (
    .clk_sys_i   (clk_sys_i),
    .rst_sys_ni  (rst_sys_ni),
    .bus_i       (dev_bus[dev_timer]),
    .timer_irq_o (timer_irq_o)
  );

  pwm_regs #(
    .pwm_width    (pwm_width),
    .pwm_ctr_size (pwm_ctr_size)
  ) u_pwm (
    .clk_sys_i  (clk_sys_i),
    .rst_sys_ni (rst_sys_ni),
    .bus_i      (dev_bus[dev_pwm]),
    .pwm_o      (pwm_o)
  );

endmodule

`default_nettype wire

// ==== tb_periph_subsystem.sv ====
// Directed testbench for the peripheral subsystem covering bus decode, GPIO, timer and PWM
`default_nettype none

module tb_periph_subsystem;
  timeunit 1ns;
  timeprecision 1ps;
  import soc_periph_pkg::*;

  localparam int gpi_width      = 8;
  localparam int gpo_width      = 16;
  localparam int pwm_width      = 12;
  localparam int pwm_ctr_size   = 8;
  localparam int rvalid_timeout = 10;

  logic                      clk_sys_i;
  logic                      rst_sys_ni;
  logic                      host_req_i;
  logic [bus_addr_width-1:0] host_addr_i;
  logic                      host_we_i;
  logic [bus_be_width-1:0]   host_be_i;
  logic [bus_data_width-1:0] host_wdata_i;
  logic                      host_rvalid_o;
  logic [bus_data_width-1:0] host_rdata_o;
  logic                      host_err_o;
  logic [gpi_width-1:0]      gp_i;
  logic [gpo_width-1:0]      gp_o;
  logic [pwm_width-1:0]      pwm_o;
  logic                      timer_irq_o;

  int test_errors;
  int pass_count;
  int fail_count;

  periph_subsystem #(
    .gpi_width    (gpi_width),
    .gpo_width    (gpo_width),
    .pwm_width    (pwm_width),
    .pwm_ctr_size (pwm_ctr_size)
  ) UUT (
    .clk_sys_i     (clk_sys_i),
    .rst_sys_ni    (rst_sys_ni),
    .host_req_i    (host_req_i),
    .host_addr_i   (host_addr_i),
    .host_we_i     (host_we_i),
    .host_be_i     (host_be_i),
    .host_wdata_i  (host_wdata_i),
    .host_rvalid_o (host_rvalid_o),
    .host_rdata_o  (host_rdata_o),
    .host_err_o    (host_err_o),
    .gp_i          (gp_i),
    .gp_o          (gp_o),
    .pwm_o         (pwm_o),
    .timer_irq_o   (timer_irq_o)
  );

  // 20 ns period
  always #10 clk_sys_i = ~clk_sys_i;

  task automatic value_error(input string name, input logic [63:0] got, input logic [63:0] exp);
    $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
    test_errors++;
  endtask

  task automatic test_done(input string name);
    if (test_errors == 0) begin
      pass_count++;
      $display("PASS  %s", name);
    end else begin
      fail_count++;
      $display("FAIL  %s, %0d errors", name, test_errors);
    end
    test_errors = 0;
  endtask

  // One request strobe, then wait for the answer
  task automatic bus_access(input logic we, input logic [31:0] addr, input logic [3:0] be,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    int wait_cnt;
    @(negedge clk_sys_i);
    host_req_i   = 1'b1;
    host_we_i    = we;
    host_addr_i  = addr;
    host_be_i    = be;
    host_wdata_i = wdata;
    @(negedge clk_sys_i);
    host_req_i = 1'b0;
    host_we_i  = 1'b0;
    wait_cnt   = 0;
    while (!host_rvalid_o && wait_cnt < rvalid_timeout) begin
      @(negedge clk_sys_i);
      wait_cnt++;
    end
    rdata = host_rdata_o;
    err   = host_err_o;
    if (!host_rvalid_o) begin
      $display("Timeout: no host_rvalid_o for the access to address 0x%08h", addr);
      test_errors++;
    end
  endtask

  task automatic write_reg(input logic [31:0] addr, input logic [3:0] be,
                           input logic [31:0] wdata);
    logic [31:0] rdata;
    logic        err;
    bus_access(1'b1, addr, be, wdata, rdata, err);
    if (err !== 1'b0) value_error("host_err_o", err, 0);
    if (rdata !== 32'h0) value_error("host_rdata_o", rdata, 0);
  endtask

  task automatic read_reg(input logic [31:0] addr, output logic [31:0] rdata,
                          output logic err);
    bus_access(1'b0, addr, 4'hF, 32'h0, rdata, err);
  endtask

  task automatic reset_and_unmapped();
    logic [31:0] rd;
    logic        err;
    if (gp_o !== '0) value_error("gp_o", gp_o, 0);
    if (pwm_o !== '0) value_error("pwm_o", pwm_o, 0);
    if (timer_irq_o !== 1'b0) value_error("timer_irq_o", timer_irq_o, 0);
    read_reg(32'h4000_0000, rd, err);
    if (err !== 1'b1) value_error("host_err_o", err, 1);
    if (rd !== 32'h0) value_error("host_rdata_o", rd, 0);
    read_reg(gpio_start, rd, err);
    if (err !== 1'b0) value_error("host_err_o", err, 0);
    read_reg(timer_start, rd, err);
    if (err !== 1'b0) value_error("host_err_o", err, 0);
    read_reg(pwm_start, rd, err);
    if (err !== 1'b0) value_error("host_err_o", err, 0);
    test_done("reset and unmapped address");
  endtask

  task automatic gpio_access();
    logic [31:0] first;
    logic [31:0] second;
    logic [31:0] merged;
    logic [31:0] rd;
    logic [31:0] in_val;
    logic        err;
    int          lane;
    first  = $urandom;
    second = $urandom;
    lane   = $urandom_range(0, 1);
    merged = first;
    merged[lane*8 +: 8] = second[lane*8 +: 8];
    write_reg(gpio_start + gpio_out_off, 4'hF, first);
    write_reg(gpio_start + gpio_out_off, 4'h1 << lane, second);
    if (gp_o !== merged[15:0]) value_error("gp_o", gp_o, merged[15:0]);
    read_reg(gpio_start + gpio_out_off, rd, err);
    if (rd !== {16'h0, merged[15:0]}) value_error("host_rdata_o", rd, {16'h0, merged[15:0]});
    // Input pins pass two sync flops
    in_val = $urandom;
    @(negedge clk_sys_i);
    gp_i = in_val[7:0];
    repeat (2) @(negedge clk_sys_i);
    read_reg(gpio_start + gpio_in_off, rd, err);
    if (rd !== {24'h0, in_val[7:0]}) value_error("host_rdata_o", rd, {24'h0, in_val[7:0]});
    test_done("gpio byte writes and input sync");
  endtask

  task automatic timer_interrupt();
    logic [31:0] t1;
    logic [31:0] t2;
    logic        err;
    int          wait_cnt;
    read_reg(timer_start + timer_mtime_lo_off, t1, err);
    read_reg(timer_start + timer_mtime_lo_off, t2, err);
    if (t2 <= t1) begin
      $display("ERROR mtime: second read 0x%08h is not above first read 0x%08h", t2, t1);
      test_errors++;
    end
    write_reg(timer_start + timer_cmp_hi_off, 4'hF, 32'h0);
    write_reg(timer_start + timer_cmp_lo_off, 4'hF, t2 + 32'd50);
    if (timer_irq_o !== 1'b0) value_error("timer_irq_o", timer_irq_o, 0);
    wait_cnt = 0;
    while (timer_irq_o !== 1'b1 && wait_cnt < 200) begin
      @(negedge clk_sys_i);
      wait_cnt++;
    end
    if (timer_irq_o !== 1'b1) begin
      $display("Timeout: timer_irq_o did not rise after mtime passed the compare value");
      test_errors++;
    end
    write_reg(timer_start + timer_cmp_hi_off, 4'hF, 32'hFFFF_FFFF);
    write_reg(timer_start + timer_cmp_lo_off, 4'hF, 32'hFFFF_FFFF);
    wait_cnt = 0;
    while (timer_irq_o !== 1'b0 && wait_cnt < 20) begin
      @(negedge clk_sys_i);
      wait_cnt++;
    end
    if (timer_irq_o !== 1'b0) begin
      $display("Timeout: timer_irq_o stayed high after compare was set to all ones");
      test_errors++;
    end
    test_done("timer count and interrupt");
  endtask

  task automatic timer_bad_offset();
    logic [31:0] rd;
    logic        err;
    read_reg(timer_start + 32'h10, rd, err);
    if (err !== 1'b1) value_error("host_err_o", err, 1);
    test_done("timer bad offset");
  endtask

  task automatic pwm_duty();
    int chan [3];
    int widths [3];
    int high_cnt [3];
    widths  = '{0, 64, 255};
    chan[0] = $urandom_range(0, pwm_width - 1);
    chan[1] = (chan[0] + 1 + $urandom_range(0, 4)) % pwm_width;
    chan[2] = (chan[0] + 6 + $urandom_range(0, 4)) % pwm_width;
    for (int k = 0; k < 3; k++) begin
      write_reg(pwm_start + chan[k] * pwm_chan_stride + pwm_period_off, 4'hF, 32'd255);
      write_reg(pwm_start + chan[k] * pwm_chan_stride + pwm_width_off, 4'hF, widths[k]);
      high_cnt[k] = 0;
    end
    // Period 255 gives a 256 clock cycle, so any window of 256 sees width high clocks
    for (int n = 0; n < 256; n++) begin
      @(negedge clk_sys_i);
      for (int k = 0; k < 3; k++) begin
        if (pwm_o[chan[k]]) high_cnt[k]++;
      end
    end
    for (int k = 0; k < 3; k++) begin
      if (high_cnt[k] != widths[k]) value_error($sformatf("pwm_o[%0d] high count", chan[k]),
                                                high_cnt[k], widths[k]);
    end
    test_done("pwm duty");
  endtask

  task automatic pwm_readback();
    logic [7:0]  period_val [pwm_width];
    logic [7:0]  width_val [pwm_width];
    logic [31:0] rd;
    logic [31:0] base;
    logic        err;
    for (int c = 0; c < pwm_width; c++) begin
      rd            = $urandom;
      period_val[c] = rd[7:0];
      width_val[c]  = rd[15:8];
      base          = pwm_start + c * pwm_chan_stride;
      write_reg(base + pwm_period_off, 4'hF, {24'h0, period_val[c]});
      write_reg(base + pwm_width_off, 4'hF, {24'h0, width_val[c]});
    end
    for (int c = 0; c < pwm_width; c++) begin
      base = pwm_start + c * pwm_chan_stride;
      read_reg(base + pwm_period_off, rd, err);
      if (rd !== {24'h0, period_val[c]}) value_error("host_rdata_o", rd, period_val[c]);
      read_reg(base + pwm_width_off, rd, err);
      if (rd !== {24'h0, width_val[c]}) value_error("host_rdata_o", rd, width_val[c]);
    end
    base = pwm_start + pwm_width * pwm_chan_stride;
    read_reg(base + pwm_period_off, rd, err);
    if (rd !== 32'h0) value_error("host_rdata_o", rd, 0);
    read_reg(base + pwm_width_off, rd, err);
    if (rd !== 32'h0) value_error("host_rdata_o", rd, 0);
    test_done("pwm register readback");
  endtask

  initial begin
    void'($urandom(71374));
    clk_sys_i    = 1'b0;
    rst_sys_ni   = 1'b0;
    host_req_i   = 1'b0;
    host_addr_i  = '0;
    host_we_i    = 1'b0;
    host_be_i    = '0;
    host_wdata_i = '0;
    gp_i         = '0;
    test_errors  = 0;
    pass_count   = 0;
    fail_count   = 0;
    repeat (4) @(negedge clk_sys_i);
    rst_sys_ni = 1'b1;

    reset_and_unmapped();
    gpio_access();
    timer_interrupt();
    timer_bad_offset();
    pwm_duty();
    pwm_readback();

    $display("Summary: %0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
soc_periph_pkg.sv
dev_bus_if.sv
pwm_channel.sv
pwm_regs.sv
gpio_regs.sv
timer_regs.sv
periph_bus.sv
periph_subsystem.sv
tb_periph_subsystem.sv

// ==== Makefile ====
# Verilator build and run for the peripheral subsystem testbench

TOP      ?= tb_periph_subsystem
FILELIST ?= vlog.f
BUILD    ?= obj_dir
LOG      ?= sim.log
VFLAGS   ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  = test failed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator from $(FILELIST) and run $(TOP), output in $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   list these targets"
	@echo "Variables: TOP LOG VFLAGS FILELIST BUILD"

test:
	verilator $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported failure"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
